//--- verilog/accel_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// accelerator control package
// opcodes, field widths, fetcher state codes and the
// two views of the 64-bit instruction word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package accel_pkg;

    // opcodes
    localparam logic [7:0] OP_SET_FLAGS    = 8'h01;
    localparam logic [7:0] OP_FETCH_BURST  = 8'h02;
    localparam logic [7:0] OP_FETCH_SINGLE = 8'h04;
    localparam logic [7:0] OP_CONV_CFG     = 8'h81;

    // field widths
    localparam int INSTR_W = 64;
    localparam int ADDR_W  = 16;
    localparam int DST_W   = 8;
    localparam int COUNT_W = 8;

    // weight fetcher phases
    localparam logic [1:0] WF_IDLE   = 2'd0;
    localparam logic [1:0] WF_WEIGHT = 2'd1;
    localparam logic [1:0] WF_BIAS   = 2'd2;
    localparam logic [1:0] WF_SCALER = 2'd3;

    // view used by opcodes 0x01, 0x02 and 0x04
    typedef struct packed {
        logic [7:0]         opcode;
        logic [7:0]         fetch_type;
        logic [ADDR_W-1:0]  src_addr;
        logic [7:0]         reserved;
        logic [DST_W-1:0]   dst_addr;
        logic [7:0]         mem_sel;
        logic [COUNT_W-1:0] fetch_count;
    } instr_fetch_t;

    // view used by opcode 0x81
    typedef struct packed {
        logic [7:0]  opcode;
        logic [4:0]  kernel_pad;
        logic [2:0]  kernel_size;
        logic [7:0]  feature_size;
        logic [7:0]  cfg_flags;
        logic [31:0] reserved;
    } instr_conv_t;

    // same word, read through the view the opcode selects
    typedef union packed {
        instr_fetch_t fetch;
        instr_conv_t  conv;
    } instr_t;

endpackage

//--- verilog/instruction_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decoder
// registers one instruction per strobe and turns it
// into fetch starts, sticky flags and config loads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module instruction_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  accel_pkg::instr_t            instruction,
    input  logic                         instr_enable,
    output logic                         feature_start,
    output logic                         weight_start,
    output logic                         cfg_load,
    output logic [accel_pkg::ADDR_W-1:0] src_addr,
    output logic [accel_pkg::DST_W-1:0]  dst_addr,
    output logic [7:0]                   mem_sel,
    output logic [accel_pkg::COUNT_W:0]  burst_len,
    output logic                         bias_en,
    output logic                         scaler_en,
    output logic [2:0]                   kernel_size,
    output logic [7:0]                   feature_size,
    output logic [7:0]                   cfg_flags
);

    accel_pkg::instr_t instr_q;
    logic [7:0]        opcode;
    logic              is_fetch;
    logic              is_conv;

    // held for one cycle only, so each strobe decodes once
    always_ff @(posedge clk) begin
        if (rst || !instr_enable) begin
            instr_q <= '0;
        end else begin
            instr_q <= instruction;
        end
    end

    // opcode sits in the top byte of both views
    assign opcode   = instr_q.fetch.opcode;
    assign is_fetch = (opcode == accel_pkg::OP_FETCH_BURST) ||
                      (opcode == accel_pkg::OP_FETCH_SINGLE);
    assign is_conv  = (opcode == accel_pkg::OP_CONV_CFG);

    // strobes and sticky flags
    always_ff @(posedge clk) begin
        if (rst) begin
            feature_start <= 1'b0;
            weight_start  <= 1'b0;
            cfg_load      <= 1'b0;
            bias_en       <= 1'b0;
            scaler_en     <= 1'b0;
        end else begin
            feature_start <= is_fetch && !instr_q.fetch.fetch_type[0];
            weight_start  <= is_fetch && instr_q.fetch.fetch_type[0];
            cfg_load      <= is_conv;
            if (opcode == accel_pkg::OP_SET_FLAGS) begin
                bias_en   <= instr_q.fetch.fetch_type[1];
                scaler_en <= instr_q.fetch.fetch_type[2];
            end
        end
    end

    // field payload, only meaningful alongside its strobe
    always_ff @(posedge clk) begin
        if (is_fetch) begin
            src_addr <= instr_q.fetch.src_addr;
            dst_addr <= instr_q.fetch.dst_addr;
            mem_sel  <= instr_q.fetch.mem_sel;
            // burst_len counts words; a fetch_count of 0 is one word
            if (opcode == accel_pkg::OP_FETCH_BURST) begin
                burst_len <= {1'b0, instr_q.fetch.fetch_count} + 1'b1;
            end else begin
                burst_len <= {{accel_pkg::COUNT_W{1'b0}}, 1'b1};
            end
        end
        if (is_conv) begin
            kernel_size  <= instr_q.conv.kernel_size;
            feature_size <= instr_q.conv.feature_size;
            cfg_flags    <= instr_q.conv.cfg_flags;
        end
    end

    // every start or load traces back to a strobe two edges earlier
    a_start_from_strobe: assert property (
        @(posedge clk) disable iff (rst)
        (feature_start || weight_start || cfg_load) |-> $past(instr_enable, 2)
    ) else $error("decoder: start or load without a strobe two cycles earlier");

endmodule

//--- verilog/feature_fetcher.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// feature fetcher
// burst of feature reads written into one of the
// two on-chip feature RAMs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module feature_fetcher (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic [accel_pkg::ADDR_W-1:0] src_addr,
    input  logic [accel_pkg::DST_W-1:0]  dst_addr,
    input  logic [7:0]                   mem_sel,
    input  logic [accel_pkg::COUNT_W:0]  burst_len,
    output logic                         rd_valid,
    output logic [accel_pkg::ADDR_W-1:0] rd_addr,
    output logic [accel_pkg::DST_W-1:0]  wr_addr,
    output logic                         ram_sel,
    output logic                         busy,
    output logic                         done
);

    // words left after the one on the bus
    logic [accel_pkg::COUNT_W:0] remain;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            remain   <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    rd_valid <= 1'b1;
                    busy     <= 1'b1;
                    remain   <= burst_len - 1'b1;
                end
            end else if (remain == '0) begin
                // last read is on the bus this cycle
                rd_valid <= 1'b0;
                busy     <= 1'b0;
                done     <= 1'b1;
            end else begin
                remain <= remain - 1'b1;
            end
        end
    end

    // read and write addresses step together
    always_ff @(posedge clk) begin
        if (!busy && start) begin
            rd_addr <= src_addr;
            wr_addr <= dst_addr;
            ram_sel <= mem_sel[0];
        end else if (busy) begin
            rd_addr <= rd_addr + 1'b1;
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // decoder must wait for done before the next feature fetch
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !busy
    ) else $error("feature_fetcher: start while busy");

    // a zero length would wrap the word counter
    a_len_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        (start && !busy) |-> (burst_len != '0)
    ) else $error("feature_fetcher: start with zero burst length");

endmodule

//--- verilog/weight_fetcher.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// weight fetcher
// weight burst, then optional bias and scaler reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module weight_fetcher (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic [accel_pkg::ADDR_W-1:0] src_addr,
    input  logic [accel_pkg::COUNT_W:0]  burst_len,
    input  logic                         bias_en,
    input  logic                         scaler_en,
    output logic                         rd_valid,
    output logic [accel_pkg::ADDR_W-1:0] rd_addr,
    output logic                         bias_rd_valid,
    output logic                         scaler_rd_valid,
    output logic                         busy,
    output logic                         done
);

    logic [1:0]                  state;
    logic [accel_pkg::COUNT_W:0] remain;
    // flags sampled at start, so a later 0x01 cannot change a burst
    logic                        bias_q;
    logic                        scaler_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= accel_pkg::WF_IDLE;
            remain <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                accel_pkg::WF_IDLE: begin
                    if (start) begin
                        state  <= accel_pkg::WF_WEIGHT;
                        remain <= burst_len - 1'b1;
                    end
                end
                accel_pkg::WF_WEIGHT: begin
                    if (remain != '0) begin
                        remain <= remain - 1'b1;
                    end else if (bias_q) begin
                        state <= accel_pkg::WF_BIAS;
                    end else if (scaler_q) begin
                        state <= accel_pkg::WF_SCALER;
                    end else begin
                        state <= accel_pkg::WF_IDLE;
                        done  <= 1'b1;
                    end
                end
                accel_pkg::WF_BIAS: begin
                    state <= scaler_q ? accel_pkg::WF_SCALER : accel_pkg::WF_IDLE;
                    done  <= !scaler_q;
                end
                default: begin
                    state <= accel_pkg::WF_IDLE;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    // bias and scaler reuse the address after the last weight
    always_ff @(posedge clk) begin
        if (state == accel_pkg::WF_IDLE && start) begin
            rd_addr  <= src_addr;
            bias_q   <= bias_en;
            scaler_q <= scaler_en;
        end else if (state == accel_pkg::WF_WEIGHT) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    assign rd_valid        = (state == accel_pkg::WF_WEIGHT);
    assign bias_rd_valid   = (state == accel_pkg::WF_BIAS);
    assign scaler_rd_valid = (state == accel_pkg::WF_SCALER);
    assign busy            = (state != accel_pkg::WF_IDLE);

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !busy
    ) else $error("weight_fetcher: start while busy");

    // phases whose flag was clear at start are skipped
    a_phase_flags: assert property (
        @(posedge clk) disable iff (rst)
        !(bias_rd_valid && !bias_q) && !(scaler_rd_valid && !scaler_q)
    ) else $error("weight_fetcher: bias or scaler read with its flag clear");

endmodule

//--- verilog/conv_config.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// convolution configuration
// layer settings and ping-pong feature RAM select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module conv_config (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic [2:0] kernel_size,
    input  logic [7:0] feature_size,
    input  logic [7:0] cfg_flags,
    output logic [2:0] current_kernel_size,
    output logic [7:0] feature_size_out,
    output logic       line_buffer_enable,
    output logic       line_buffer_mod,
    output logic       feature_in_select,
    output logic       feature_out_select
);

    always_ff @(posedge clk) begin
        if (rst) begin
            current_kernel_size <= '0;
            feature_size_out    <= '0;
            line_buffer_enable  <= 1'b0;
            line_buffer_mod     <= 1'b0;
            feature_in_select   <= 1'b0;
        end else if (load) begin
            current_kernel_size <= kernel_size;
            feature_size_out    <= feature_size;
            line_buffer_enable  <= cfg_flags[0];
            line_buffer_mod     <= cfg_flags[1];
            // swap: last layer's output RAM becomes this layer's input
            if (cfg_flags[2]) begin
                feature_in_select <= !feature_in_select;
            end
        end
    end

    // compute array always writes to the RAM it is not reading
    assign feature_out_select = !feature_in_select;

    // kernel size comes straight from the instruction word
    a_kernel_odd: assert property (
        @(posedge clk) disable iff (rst)
        load |-> kernel_size inside {3'd1, 3'd3, 3'd5, 3'd7}
    ) else $error("conv_config: illegal kernel size %0d", kernel_size);

endmodule

//--- verilog/accel_ctrl_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// accelerator control front end
// decoder driving feature fetch, weight fetch and
// the convolution configuration block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module accel_ctrl_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [accel_pkg::INSTR_W-1:0] instruction,
    input  logic                          instr_enable,
    // feature fetcher
    output logic                          feature_rd_valid,
    output logic [accel_pkg::ADDR_W-1:0]  feature_rd_addr,
    output logic [accel_pkg::DST_W-1:0]   feature_wr_addr,
    output logic                          feature_ram_sel,
    output logic                          feature_busy,
    output logic                          feature_done,
    // weight fetcher
    output logic                          weight_rd_valid,
    output logic [accel_pkg::ADDR_W-1:0]  weight_rd_addr,
    output logic                          bias_rd_valid,
    output logic                          scaler_rd_valid,
    output logic                          weight_busy,
    output logic                          weight_done,
    // convolution config
    output logic [2:0]                    current_kernel_size,
    output logic [7:0]                    feature_size,
    output logic                          line_buffer_enable,
    output logic                          line_buffer_mod,
    output logic                          feature_in_select,
    output logic                          feature_out_select
);

    logic                         feature_start;
    logic                         weight_start;
    logic                         cfg_load;
    logic [accel_pkg::ADDR_W-1:0] src_addr;
    logic [accel_pkg::DST_W-1:0]  dst_addr;
    logic [7:0]                   mem_sel;
    logic [accel_pkg::COUNT_W:0]  burst_len;
    logic                         bias_en;
    logic                         scaler_en;
    logic [2:0]                   kernel_size;
    logic [7:0]                   cfg_feature_size;
    logic [7:0]                   cfg_flags;

    instruction_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .instruction  (instruction),
        .instr_enable (instr_enable),
        .feature_start(feature_start),
        .weight_start (weight_start),
        .cfg_load     (cfg_load),
        .src_addr     (src_addr),
        .dst_addr     (dst_addr),
        .mem_sel      (mem_sel),
        .burst_len    (burst_len),
        .bias_en      (bias_en),
        .scaler_en    (scaler_en),
        .kernel_size  (kernel_size),
        .feature_size (cfg_feature_size),
        .cfg_flags    (cfg_flags)
    );

    feature_fetcher u_feature (
        .clk      (clk),
        .rst      (rst),
        .start    (feature_start),
        .src_addr (src_addr),
        .dst_addr (dst_addr),
        .mem_sel  (mem_sel),
        .burst_len(burst_len),
        .rd_valid (feature_rd_valid),
        .rd_addr  (feature_rd_addr),
        .wr_addr  (feature_wr_addr),
        .ram_sel  (feature_ram_sel),
        .busy     (feature_busy),
        .done     (feature_done)
    );

    weight_fetcher u_weight (
        .clk            (clk),
        .rst            (rst),
        .start          (weight_start),
        .src_addr       (src_addr),
        .burst_len      (burst_len),
        .bias_en        (bias_en),
        .scaler_en      (scaler_en),
        .rd_valid       (weight_rd_valid),
        .rd_addr        (weight_rd_addr),
        .bias_rd_valid  (bias_rd_valid),
        .scaler_rd_valid(scaler_rd_valid),
        .busy           (weight_busy),
        .done           (weight_done)
    );

    conv_config u_conv_cfg (
        .clk                (clk),
        .rst                (rst),
        .load               (cfg_load),
        .kernel_size        (kernel_size),
        .feature_size       (cfg_feature_size),
        .cfg_flags          (cfg_flags),
        .current_kernel_size(current_kernel_size),
        .feature_size_out   (feature_size),
        .line_buffer_enable (line_buffer_enable),
        .line_buffer_mod    (line_buffer_mod),
        .feature_in_select  (feature_in_select),
        .feature_out_select (feature_out_select)
    );

endmodule

//--- dv/clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// 100 ns clock, reset held for 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- dv/tb_accel_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// accelerator control testbench
// random fetch and config instructions, checked
// against a schedule indexed by clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_accel_ctrl;

    logic                         clk;
    logic                         rst;
    accel_pkg::instr_t            instruction;
    logic                         instr_enable;

    logic                         feature_rd_valid;
    logic [accel_pkg::ADDR_W-1:0] feature_rd_addr;
    logic [accel_pkg::DST_W-1:0]  feature_wr_addr;
    logic                         feature_ram_sel;
    logic                         feature_busy;
    logic                         feature_done;
    logic                         weight_rd_valid;
    logic [accel_pkg::ADDR_W-1:0] weight_rd_addr;
    logic                         bias_rd_valid;
    logic                         scaler_rd_valid;
    logic                         weight_busy;
    logic                         weight_done;
    logic [2:0]                   current_kernel_size;
    logic [7:0]                   feature_size;
    logic                         line_buffer_enable;
    logic                         line_buffer_mod;
    logic                         feature_in_select;
    logic                         feature_out_select;

    // posedge count, the key of every schedule below
    int    cyc = 0;
    int    errors = 0;
    int    timeouts = 0;
    string test_name = "reset";

    // expected activity, keyed by the edge after which it shows
    logic [24:0]       f_sched [int];
    logic [18:0]       w_sched [int];
    bit                f_done [int];
    bit                w_done [int];
    accel_pkg::instr_t cfg_sched [int];

    // sticky flags as the DUT should hold them
    bit m_bias = 1'b0;
    bit m_scaler = 1'b0;

    logic              exp_f_valid = 1'b0;
    logic [24:0]       exp_f_word = '0;
    logic              exp_f_done = 1'b0;
    logic [2:0]        exp_w_kind = '0;
    logic [15:0]       exp_w_addr = '0;
    logic              exp_w_done = 1'b0;
    logic [13:0]       exp_cfg = '0;
    accel_pkg::instr_t cfg_word;

    clk_gen u_clk (
        .clk(clk),
        .rst(rst)
    );

    accel_ctrl_top DUT (
        .clk                (clk),
        .rst                (rst),
        .instruction        (instruction),
        .instr_enable       (instr_enable),
        .feature_rd_valid   (feature_rd_valid),
        .feature_rd_addr    (feature_rd_addr),
        .feature_wr_addr    (feature_wr_addr),
        .feature_ram_sel    (feature_ram_sel),
        .feature_busy       (feature_busy),
        .feature_done       (feature_done),
        .weight_rd_valid    (weight_rd_valid),
        .weight_rd_addr     (weight_rd_addr),
        .bias_rd_valid      (bias_rd_valid),
        .scaler_rd_valid    (scaler_rd_valid),
        .weight_busy        (weight_busy),
        .weight_done        (weight_done),
        .current_kernel_size(current_kernel_size),
        .feature_size       (feature_size),
        .line_buffer_enable (line_buffer_enable),
        .line_buffer_mod    (line_buffer_mod),
        .feature_in_select  (feature_in_select),
        .feature_out_select (feature_out_select)
    );

    // expected outputs after edge cyc
    always @(posedge clk) begin
        cyc = cyc + 1;
        exp_f_valid <= (f_sched.exists(cyc) != 0);
        if (f_sched.exists(cyc) != 0) begin
            exp_f_word <= f_sched[cyc];
        end
        exp_f_done <= (f_done.exists(cyc) != 0);
        exp_w_kind <= (w_sched.exists(cyc) != 0) ? w_sched[cyc][18:16] : 3'b000;
        if (w_sched.exists(cyc) != 0) begin
            exp_w_addr <= w_sched[cyc][15:0];
        end
        exp_w_done <= (w_done.exists(cyc) != 0);
        if (cfg_sched.exists(cyc) != 0) begin
            cfg_word = cfg_sched[cyc];
            // swap flag flips the input RAM
            exp_cfg <= {cfg_word.conv.kernel_size, cfg_word.conv.feature_size,
                        cfg_word.conv.cfg_flags[0], cfg_word.conv.cfg_flags[1],
                        exp_cfg[0] ^ cfg_word.conv.cfg_flags[2]};
        end
    end

    function automatic void log_mismatch(input string what, input logic [31:0] exp,
                                         input logic [31:0] act);
        errors++;
        $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
    endfunction

    a_f_valid: assert property (@(posedge clk) disable iff (rst)
        feature_rd_valid == exp_f_valid)
        else log_mismatch("feature_rd_valid", $sampled(exp_f_valid),
                          $sampled(feature_rd_valid));
    a_f_addr: assert property (@(posedge clk) disable iff (rst)
        exp_f_valid |-> {feature_ram_sel, feature_wr_addr, feature_rd_addr} == exp_f_word)
        else log_mismatch("feature sel/wr/rd", $sampled(exp_f_word),
                          $sampled({feature_ram_sel, feature_wr_addr, feature_rd_addr}));
    a_f_busy: assert property (@(posedge clk) disable iff (rst)
        feature_busy == exp_f_valid)
        else log_mismatch("feature_busy", $sampled(exp_f_valid), $sampled(feature_busy));
    a_f_done: assert property (@(posedge clk) disable iff (rst)
        feature_done == exp_f_done)
        else log_mismatch("feature_done", $sampled(exp_f_done), $sampled(feature_done));
    a_w_valid: assert property (@(posedge clk) disable iff (rst)
        {weight_rd_valid, bias_rd_valid, scaler_rd_valid} == exp_w_kind)
        else log_mismatch("weight/bias/scaler valid", $sampled(exp_w_kind),
                          $sampled({weight_rd_valid, bias_rd_valid, scaler_rd_valid}));
    a_w_addr: assert property (@(posedge clk) disable iff (rst)
        (exp_w_kind != 3'b000) |-> weight_rd_addr == exp_w_addr)
        else log_mismatch("weight_rd_addr", $sampled(exp_w_addr), $sampled(weight_rd_addr));
    a_w_busy: assert property (@(posedge clk) disable iff (rst)
        weight_busy == (exp_w_kind != 3'b000))
        else log_mismatch("weight_busy", $sampled(exp_w_kind != 3'b000),
                          $sampled(weight_busy));
    a_w_done: assert property (@(posedge clk) disable iff (rst)
        weight_done == exp_w_done)
        else log_mismatch("weight_done", $sampled(exp_w_done), $sampled(weight_done));
    a_cfg: assert property (@(posedge clk) disable iff (rst)
        {current_kernel_size, feature_size, line_buffer_enable, line_buffer_mod,
         feature_in_select} == exp_cfg)
        else log_mismatch("conv config", $sampled(exp_cfg),
                          $sampled({current_kernel_size, feature_size, line_buffer_enable,
                                    line_buffer_mod, feature_in_select}));
    a_pingpong: assert property (@(posedge clk) disable iff (rst)
        feature_out_select == !exp_cfg[0])
        else log_mismatch("feature_out_select", $sampled(!exp_cfg[0]),
                          $sampled(feature_out_select));

    // strobe at edge n: decode after n+1, first read after n+2
    task automatic schedule(input accel_pkg::instr_t ins, input int n);
        int          len;
        int          k;
        logic [15:0] a;
        logic [7:0]  w;
        case (ins.fetch.opcode)
            accel_pkg::OP_SET_FLAGS: begin
                m_bias   = ins.fetch.fetch_type[1];
                m_scaler = ins.fetch.fetch_type[2];
            end
            accel_pkg::OP_FETCH_BURST, accel_pkg::OP_FETCH_SINGLE: begin
                len = 1;
                if (ins.fetch.opcode == accel_pkg::OP_FETCH_BURST) begin
                    len = int'(ins.fetch.fetch_count) + 1;
                end
                for (k = 0; k < len; k++) begin
                    a = ins.fetch.src_addr + 16'(k);
                    w = ins.fetch.dst_addr + 8'(k);
                    if (ins.fetch.fetch_type[0]) begin
                        w_sched[n + 2 + k] = {3'b100, a};
                    end else begin
                        f_sched[n + 2 + k] = {ins.fetch.mem_sel[0], w, a};
                    end
                end
                if (ins.fetch.fetch_type[0]) begin
                    // bias and scaler read the word after the last weight
                    a = ins.fetch.src_addr + 16'(len);
                    k = n + 2 + len;
                    if (m_bias) begin
                        w_sched[k] = {3'b010, a};
                        k++;
                    end
                    if (m_scaler) begin
                        w_sched[k] = {3'b001, a};
                        k++;
                    end
                    w_done[k] = 1'b1;
                end else begin
                    f_done[n + 2 + len] = 1'b1;
                end
            end
            accel_pkg::OP_CONV_CFG: cfg_sched[n + 2] = ins;
            default: ;
        endcase
    endtask

    function automatic accel_pkg::instr_t make_fetch(input logic [7:0] op,
                                                     input logic [7:0] ftype,
                                                     input logic [7:0] count);
        accel_pkg::instr_t ins;
        ins = '0;
        ins.fetch.opcode      = op;
        ins.fetch.fetch_type  = ftype;
        ins.fetch.src_addr    = 16'($urandom);
        ins.fetch.dst_addr    = 8'($urandom);
        ins.fetch.mem_sel     = 8'($urandom);
        ins.fetch.fetch_count = count;
        return ins;
    endfunction

    function automatic accel_pkg::instr_t make_conv(input logic [2:0] ks,
                                                    input logic [7:0] fs,
                                                    input logic [7:0] flags);
        accel_pkg::instr_t ins;
        ins = '0;
        ins.conv.opcode       = accel_pkg::OP_CONV_CFG;
        ins.conv.kernel_size  = ks;
        ins.conv.feature_size = fs;
        ins.conv.cfg_flags    = flags;
        return ins;
    endfunction

    // one-cycle strobe, driven on the falling edge
    task automatic issue(input accel_pkg::instr_t ins, input bit en);
        @(negedge clk);
        instruction  = ins;
        instr_enable = en;
        if (en) begin
            schedule(ins, cyc + 1);
        end
        @(negedge clk);
        instr_enable = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_reset();
        int t;
        for (t = 0; t < 40; t++) begin
            @(negedge clk);
            if (!rst) break;
        end
        if (rst) begin
            timeouts++;
            $display("timeout: reset was never released");
        end
    endtask

    task automatic wait_done(input bit weight);
        int t;
        for (t = 0; t < 400; t++) begin
            @(negedge clk);
            if (weight ? weight_done : feature_done) break;
        end
        if (t == 400) begin
            timeouts++;
            $display("timeout in %s: %s fetcher never signalled done", test_name,
                     weight ? "weight" : "feature");
        end
    endtask

    initial begin
        int i;
        void'($urandom(32'h467b_131d));
        instruction  = '0;
        instr_enable = 1'b0;
        wait_reset();
        idle(3);

        test_name = "feature burst";
        for (i = 0; i < 5; i++) begin
            issue(make_fetch(accel_pkg::OP_FETCH_BURST, 8'h00,
                             (i == 0) ? 8'd0 : 8'($urandom_range(1, 24))), 1'b1);
            wait_done(1'b0);
        end

        // count field is ignored, fetch_type bit 0 picks the fetcher
        test_name = "single fetch";
        for (i = 0; i < 4; i++) begin
            issue(make_fetch(accel_pkg::OP_FETCH_SINGLE, {7'd0, i[0]}, 8'($urandom)), 1'b1);
            wait_done(i[0]);
        end

        test_name = "weight burst with flags";
        for (i = 0; i < 4; i++) begin
            issue(make_fetch(accel_pkg::OP_SET_FLAGS, {5'd0, i[1:0], 1'b0}, 8'd0), 1'b1);
            issue(make_fetch(accel_pkg::OP_FETCH_BURST, 8'h01,
                             8'($urandom_range(0, 12))), 1'b1);
            wait_done(1'b1);
        end

        // config shows 3 edges after the strobe
        test_name = "conv config";
        for (i = 0; i < 6; i++) begin
            issue(make_conv(3'(2 * $urandom_range(0, 3) + 1), 8'($urandom),
                            8'($urandom_range(0, 7))), 1'b1);
            idle(3);
        end

        test_name = "ignored and idle";
        issue(make_fetch(8'h55, 8'h00, 8'd4), 1'b1);
        issue(make_fetch(8'h80, 8'h01, 8'd4), 1'b1);
        issue(make_fetch(accel_pkg::OP_FETCH_BURST, 8'h00, 8'd4), 1'b0);
        issue(make_conv(3'd3, 8'h20, 8'h04), 1'b0);
        idle(12);

        $display("checks finished: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- list.f
verilog/accel_pkg.sv
verilog/instruction_decode.sv
verilog/feature_fetcher.sv
verilog/weight_fetcher.sv
verilog/conv_config.sv
verilog/accel_ctrl_top.sv
dv/clk_gen.sv
dv/tb_accel_ctrl.sv

//--- run.sh
#!/bin/sh
# build the accelerator control testbench with Verilator and run it
# the run passes only if the simulation prints the pass message

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_accel_ctrl -f list.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep "Everything OK" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
